// ==== common/memCmdPkg.sv ====
`include "mpram_defs.svh"

package memCmdPkg;

  typedef logic [`MPRAM_TAG_W-1:0] tag_t; // read tag, returned with the read data

  // write view: isWrite, address, data
  typedef struct packed {
    logic              isWrite; // always 1 in this view
    memGeomPkg::addr_t addr;    // target word
    memGeomPkg::data_t data;    // value to store
  } writeCmd_s;

  // read view: isWrite, address, tag, pad to the write view width
  typedef struct packed {
    logic                                 isWrite; // always 0 in this view
    memGeomPkg::addr_t                    addr;    // word to fetch
    tag_t                                 tag;     // echoed on rspTag
    logic [`MPRAM_DATA_W-`MPRAM_TAG_W-1:0] unused; // don't care
  } readCmd_s;

  // one 21-bit command word, top bit picks the view
  typedef union packed {
    writeCmd_s wr;
    readCmd_s  rd;
  } cmdWord_u;

endpackage

// ==== common/memGeomPkg.sv ====
`include "mpram_defs.svh"

package memGeomPkg;

  // word address, 4 bits for 16 words
  typedef logic [$clog2(`MPRAM_DEPTH)-1:0] addr_t;

  // one data word as held in a bank
  typedef logic [`MPRAM_DATA_W-1:0] data_t;

  // bank number, i.e. the port whose bank last wrote an address
  typedef logic [$clog2(`MPRAM_PORTS)-1:0] bankSel_t;

endpackage

// ==== common/mpram_defs.svh ====
`ifndef MPRAM_DEFS_SVH
`define MPRAM_DEFS_SVH

// geometry of the two-port LVT memory
`define MPRAM_DEPTH  16 // words per bank
`define MPRAM_DATA_W 16 // data word width

// client side
`define MPRAM_PORTS  2  // client ports, one data bank each
`define MPRAM_TAG_W  8  // read tag echoed back with the response

`endif

// ==== compile.f ====
+incdir+common
common/memGeomPkg.sv
common/memCmdPkg.sv
source/portRequestSlave.sv
lvtMem/bankRam.sv
lvtMem/liveValueTable.sv
lvtMem/lvtMultiPortRam.sv
source/readReturnMaster.sv
source/mpramTop.sv
sim/mpram_properties.sv
sim/mpramChecker.sv
sim/mpramTb.sv

// ==== lvtMem/bankRam.sv ====
`timescale 1ns/1ps
`include "mpram_defs.svh"

module bankRam (
  input  logic              clk,                   // clock
  input  logic              rstN,                  // sync reset, active low
  input  logic              wrEn,                  // write from the owning port
  input  memGeomPkg::addr_t wrAddr,                // write address
  input  memGeomPkg::data_t wrData,                // write data
  input  memGeomPkg::addr_t rdAddr [`MPRAM_PORTS], // one read address per port
  output memGeomPkg::data_t rdData [`MPRAM_PORTS]  // registered read data
);

  import memGeomPkg::*;

  data_t mem [`MPRAM_DEPTH]; // bank storage

  // single write port, whole bank cleared by reset
  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int a = 0; a < `MPRAM_DEPTH; a++) begin
        mem[a] <= '0;
      end
    end else if (wrEn) begin
      mem[wrAddr] <= wrData;
    end
  end

  // two sync read ports, old data on same-address collision
  always_ff @(posedge clk) begin
    for (int r = 0; r < `MPRAM_PORTS; r++) begin
      rdData[r] <= mem[rdAddr[r]];
    end
  end

endmodule

// ==== lvtMem/liveValueTable.sv ====
`timescale 1ns/1ps
`include "mpram_defs.svh"

module liveValueTable (
  input  logic                 clk,                   // clock
  input  logic                 rstN,                  // sync reset, active low
  input  logic                 wrEn   [`MPRAM_PORTS], // write enable per port
  input  memGeomPkg::addr_t    wrAddr [`MPRAM_PORTS], // write address per port
  input  memGeomPkg::addr_t    rdAddr [`MPRAM_PORTS], // read address per port
  output memGeomPkg::bankSel_t rdBank [`MPRAM_PORTS]  // live bank, one cycle later
);

  import memGeomPkg::*;

  bankSel_t lvt [`MPRAM_DEPTH]; // live bank per address

  // record the writing port, port order gives port 1 priority on a collision
  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int a = 0; a < `MPRAM_DEPTH; a++) begin
        lvt[a] <= '0; // everything lives in bank 0 after reset
      end
    end else begin
      for (int p = 0; p < `MPRAM_PORTS; p++) begin
        if (wrEn[p]) begin
          lvt[wrAddr[p]] <= bankSel_t'(p); // later p overrides earlier
        end
      end
    end
  end

  // registered lookup, lines up with the bank read registers
  // a same-cycle write is not seen here, old entry comes out
  always_ff @(posedge clk) begin
    for (int r = 0; r < `MPRAM_PORTS; r++) begin
      rdBank[r] <= lvt[rdAddr[r]];
    end
  end

endmodule

// ==== lvtMem/lvtMultiPortRam.sv ====
`timescale 1ns/1ps
`include "mpram_defs.svh"

module lvtMultiPortRam (
  input  logic              clk,                   // clock
  input  logic              rstN,                  // sync reset, active low
  input  logic              wrEn   [`MPRAM_PORTS], // write enable per port
  input  memGeomPkg::addr_t wrAddr [`MPRAM_PORTS], // write address per port
  input  memGeomPkg::data_t wrData [`MPRAM_PORTS], // write data per port
  input  memGeomPkg::addr_t rdAddr [`MPRAM_PORTS], // read address per port
  output memGeomPkg::data_t rdData [`MPRAM_PORTS]  // live read data, one cycle later
);

  import memGeomPkg::*;

  data_t    bankRd  [`MPRAM_PORTS][`MPRAM_PORTS]; // [bank][read port]
  bankSel_t liveSel [`MPRAM_PORTS];               // live bank per read port

  // one bank per write port, every bank serves every read port
  for (genvar p = 0; p < `MPRAM_PORTS; p++) begin : gBank
    bankRam bank_i (
      .clk    (clk),
      .rstN   (rstN),
      .wrEn   (wrEn[p]),   // only port p writes bank p
      .wrAddr (wrAddr[p]),
      .wrData (wrData[p]),
      .rdAddr (rdAddr),
      .rdData (bankRd[p])
    );
  end

  // which bank holds the newest value for each address
  liveValueTable lvt_i (
    .clk    (clk),
    .rstN   (rstN),
    .wrEn   (wrEn),
    .wrAddr (wrAddr),
    .rdAddr (rdAddr),
    .rdBank (liveSel) // registered, same cycle as bankRd
  );

  // output muxes, pick the live bank per read port
  for (genvar r = 0; r < `MPRAM_PORTS; r++) begin : gSel
    assign rdData[r] = bankRd[liveSel[r]][r];
  end

endmodule

// ==== sim/mpramChecker.sv ====
`timescale 1ns/1ps

module mpramChecker (
  input  logic                clk,       // clock
  input  logic                rstN,      // sync reset, active low
  input  logic                cmdAckP0,  // port 0 command ack
  input  memCmdPkg::cmdWord_u cmdWordP0, // port 0 command, held while req high
  input  logic                rspReqP0,
  input  memGeomPkg::data_t   rspDataP0,
  input  memCmdPkg::tag_t     rspTagP0,
  input  logic                cmdAckP1,
  input  memCmdPkg::cmdWord_u cmdWordP1,
  input  logic                rspReqP1,
  input  memGeomPkg::data_t   rspDataP1,
  input  memCmdPkg::tag_t     rspTagP1,
  output int                  errCount,  // checker errors
  output int                  rspTotal   // responses seen on both ports
);

  import memGeomPkg::*;
  import memCmdPkg::*;

  logic ackQ [2];          // last sampled cmdAck
  logic reqQ [2];          // last sampled rspReq
  int   pending [2];       // reads accepted but response not yet dropped
  int   seenCnt [2][256];  // responses per tag
  tag_t tagExp [2];        // next tag due, reads come back in issue order

  task automatic watchPort(input int p, input logic ack, input logic isWr, input logic req,
                           input data_t data, input tag_t tag);
    data_t exp;
    if (ack && !ackQ[p] && !isWr) begin
      pending[p]++;
      if (pending[p] > 1) begin
        $display("port %0d: read command accepted while a response was still pending", p);
        errCount++;
      end
    end
    if (req && !reqQ[p]) begin // new response
      rspTotal++;
      seenCnt[p][tag]++;
      exp = mpramTb.expData[p][tagExp[p]];
      if (seenCnt[p][tag] > mpramTb.issCnt[p][tag]) begin
        $display("port %0d: response with tag %02h was never issued or came twice", p, tag);
        errCount++;
      end else if (tag !== tagExp[p]) begin
        $display("mismatch %s port %0d tag: expected %02h actual %02h",
                 mpramTb.testName, p, tagExp[p], tag);
        errCount++;
      end else if (data !== exp) begin
        $display("mismatch %s port %0d tag %02h: expected %04h actual %04h",
                 mpramTb.testName, p, tag, exp, data);
        errCount++;
      end
      tagExp[p]++;
    end
    if (!req && reqQ[p]) pending[p]--; // slot handed back
    ackQ[p] = ack;
    reqQ[p] = req;
  endtask

  initial begin
    errCount = 0;
    rspTotal = 0;
    for (int p = 0; p < 2; p++) begin
      ackQ[p]    = 1'b0;
      reqQ[p]    = 1'b0;
      pending[p] = 0;
      tagExp[p]  = '0;
      for (int t = 0; t < 256; t++) seenCnt[p][t] = 0;
    end
  end

  // sampled on the edge, inputs settled from the previous cycle
  always @(posedge clk) begin
    if (rstN) begin
      watchPort(0, cmdAckP0, cmdWordP0.wr.isWrite, rspReqP0, rspDataP0, rspTagP0);
      watchPort(1, cmdAckP1, cmdWordP1.wr.isWrite, rspReqP1, rspDataP1, rspTagP1);
    end
  end

endmodule

// ==== sim/mpramTb.sv ====
`timescale 1ns/1ps
`include "mpram_defs.svh"

module mpramTb;

  import memGeomPkg::*;
  import memCmdPkg::*;

  localparam int NUM_OPS = 260;                 // b1 32, b2 2, b3 6, b4 200, b5 20
  localparam int LIMIT   = 40 * NUM_OPS + 16;  // cycles before giving up

  logic     clk = 1'b0;
  logic     rstN;
  logic     cmdReqP0, cmdAckP0, rspReqP0, rspAckP0;
  logic     cmdReqP1, cmdAckP1, rspReqP1, rspAckP1;
  cmdWord_u cmdWordP0, cmdWordP1;
  data_t    rspDataP0, rspDataP1;
  tag_t     rspTagP0, rspTagP1;

  data_t model [`MPRAM_DEPTH]; // reference memory, updated on write ack
  data_t expData [2][256];     // expected data per port and tag
  int    issCnt [2][256];      // reads issued per port and tag
  tag_t  tagNext [2];
  string testName = "reset";
  int    seed = 32'h8e8e;
  int    ackMax = 0;           // response ack delay bound
  int    readCount = 0;
  int    tbErr = 0;
  int    assertErr = 0;        // failed bound assertions
  int    cycles = 0;
  int    errCount, rspTotal;

  mpramTop dut_i (.*);

  mpramChecker chk_i (
    .clk (clk), .rstN (rstN),
    .cmdAckP0 (cmdAckP0), .cmdWordP0 (cmdWordP0), .rspReqP0 (rspReqP0),
    .rspDataP0 (rspDataP0), .rspTagP0 (rspTagP0),
    .cmdAckP1 (cmdAckP1), .cmdWordP1 (cmdWordP1), .rspReqP1 (rspReqP1),
    .rspDataP1 (rspDataP1), .rspTagP1 (rspTagP1),
    .errCount (errCount), .rspTotal (rspTotal)
  );

  bind portRequestSlave mpramProperties slaveProps_i (.clk (clk), .rstN (rstN),
    .req (cmdReq), .ack (cmdAck), .pulse (issueValid), .payload ({3'b000, cmdWord}));
  bind readReturnMaster mpramProperties masterProps_i (.clk (clk), .rstN (rstN),
    .req (rspReq), .ack (rspAck), .pulse (rdIssue), .payload ({rspTag, rspData}));

  always #10 clk = ~clk; // 20 ns period

  // expected value of a word at the moment a read is issued
  function automatic data_t refRead(input addr_t a);
    return model[a];
  endfunction

  function automatic cmdWord_u makeWrite(input addr_t a, input data_t d);
    cmdWord_u w;
    w.wr.isWrite = 1'b1;
    w.wr.addr    = a;
    w.wr.data    = d;
    return w;
  endfunction

  function automatic cmdWord_u makeRead(input int p, input addr_t a);
    cmdWord_u w;
    w.rd.isWrite = 1'b0;
    w.rd.addr    = a;
    w.rd.tag     = tagNext[p];
    w.rd.unused  = '0;
    return w;
  endfunction

  task automatic noteRead(input int p, input cmdWord_u w);
    if (!w.wr.isWrite) begin
      expData[p][w.rd.tag] = refRead(w.rd.addr);
      issCnt[p][w.rd.tag]++;
      tagNext[p]++;
      readCount++;
    end
  endtask

  task automatic sendP0(input cmdWord_u w);
    noteRead(0, w);
    @(posedge clk);
    cmdReqP0  <= 1'b1;
    cmdWordP0 <= w;
    do @(posedge clk); while (!cmdAckP0);
    if (w.wr.isWrite) model[w.wr.addr] = w.wr.data; // accepted
    cmdReqP0 <= 1'b0;
    do @(posedge clk); while (cmdAckP0);
  endtask

  task automatic sendP1(input cmdWord_u w);
    noteRead(1, w);
    @(posedge clk);
    cmdReqP1  <= 1'b1;
    cmdWordP1 <= w;
    do @(posedge clk); while (!cmdAckP1);
    if (w.wr.isWrite) model[w.wr.addr] = w.wr.data;
    cmdReqP1 <= 1'b0;
    do @(posedge clk); while (cmdAckP1);
  endtask

  function automatic int ackDelay();
    return ($random(seed) & 32'h7fffffff) % (ackMax + 1);
  endfunction

  // client side of the response handshake, one per port
  always begin
    @(posedge clk);
    if (rspReqP0 && !rspAckP0) begin
      repeat (ackDelay()) @(posedge clk);
      rspAckP0 <= 1'b1;
      do @(posedge clk); while (rspReqP0);
      rspAckP0 <= 1'b0;
    end
  end

  always begin
    @(posedge clk);
    if (rspReqP1 && !rspAckP1) begin
      repeat (ackDelay()) @(posedge clk);
      rspAckP1 <= 1'b1;
      do @(posedge clk); while (rspReqP1);
      rspAckP1 <= 1'b0;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    rstN = 1'b0;
    cmdReqP0 = 1'b0;
    cmdReqP1 = 1'b0;
    rspAckP0 = 1'b0;
    rspAckP1 = 1'b0;
    cmdWordP0 = '0;
    cmdWordP1 = '0;
    tagNext[0] = '0;
    tagNext[1] = '0;
    for (int a = 0; a < `MPRAM_DEPTH; a++) model[a] = '0;
    for (int t = 0; t < 256; t++) begin
      issCnt[0][t] = 0;
      issCnt[1][t] = 0;
    end
    repeat (16) @(posedge clk);
    rstN <= 1'b1;
    @(posedge clk);
    @(posedge clk);
    if (cmdAckP0 || cmdAckP1 || rspReqP0 || rspReqP1) begin
      $display("cmdAck or rspReq not low after reset");
      tbErr++;
    end
    testName = "resetReads";
    for (int a = 0; a < `MPRAM_DEPTH; a++) begin
      sendP0(makeRead(0, addr_t'(a)));
      sendP1(makeRead(1, addr_t'(a)));
    end
    testName = "writeRead";
    sendP0(makeWrite(4'd3, 16'h1234));
    sendP0(makeRead(0, 4'd3));
    testName = "crossBank";
    sendP1(makeWrite(4'd5, 16'ha5a5));
    sendP0(makeRead(0, 4'd5));
    sendP1(makeRead(1, 4'd5));
    sendP0(makeWrite(4'd5, 16'h5a5a));
    sendP0(makeRead(0, 4'd5));
    sendP1(makeRead(1, 4'd5));
    testName = "randomMix";
    ackMax = 3;
    fork
      for (int i = 0; i < 100; i++) begin
        if ($random(seed) & 1) begin
          sendP0(makeWrite(addr_t'($random(seed) & 7), data_t'($random(seed))));
        end else begin
          sendP0(makeRead(0, addr_t'($random(seed) & 7)));
        end
      end
      for (int i = 0; i < 100; i++) begin
        if ($random(seed) & 1) begin
          sendP1(makeWrite(addr_t'(8 | ($random(seed) & 7)), data_t'($random(seed))));
        end else begin
          sendP1(makeRead(1, addr_t'(8 | ($random(seed) & 7))));
        end
      end
    join
    testName = "backPressure";
    ackMax = 12;
    fork
      for (int i = 0; i < 10; i++) sendP0(makeRead(0, addr_t'(i & 7)));
      for (int i = 0; i < 10; i++) sendP1(makeRead(1, addr_t'(8 | (i & 7))));
    join
    // every issued read must come back, a lost one ends in the timeout
    while (rspTotal != readCount || rspReqP0 || rspReqP1) @(posedge clk);
    repeat (4) @(posedge clk);
    $display("errors: %0d checker, %0d testbench, %0d assertion, %0d of %0d responses",
             errCount, tbErr, assertErr, rspTotal, readCount);
    if (errCount == 0 && tbErr == 0 && assertErr == 0 && rspTotal == readCount) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== sim/mpram_properties.sv ====
`timescale 1ns/1ps

module mpramProperties (
  input logic        clk,     // clock
  input logic        rstN,    // sync reset, active low
  input logic        req,     // four-phase request
  input logic        ack,     // four-phase acknowledge
  input logic        pulse,   // issue strobe, one cycle wide
  input logic [23:0] payload  // must hold while req waits for ack
);

  // ack may only fall once req is gone
  ackHoldsWhileReq: assert property (@(posedge clk) disable iff (!rstN)
    $fell(ack) |-> !req)
    else begin
      $error("ack dropped while req still high");
      mpramTb.assertErr++;
    end

  // request and its payload stay put until ack
  reqStableUntilAck: assert property (@(posedge clk) disable iff (!rstN)
    (req && !ack) |=> (req && $stable(payload)))
    else begin
      $error("req or payload changed before ack");
      mpramTb.assertErr++;
    end

  // issue strobe is one cycle wide
  pulseSingleCycle: assert property (@(posedge clk) disable iff (!rstN)
    pulse |=> !pulse)
    else begin
      $error("issue pulse longer than one cycle");
      mpramTb.assertErr++;
    end

endmodule

// ==== source/mpramTop.sv ====
`timescale 1ns/1ps
`include "mpram_defs.svh"

module mpramTop (
  input  logic                clk,       // clock
  input  logic                rstN,      // sync reset, active low
  input  logic                cmdReqP0,  // port 0 command request
  input  memCmdPkg::cmdWord_u cmdWordP0, // port 0 command word
  output logic                cmdAckP0,  // port 0 command ack
  output logic                rspReqP0,  // port 0 response request
  input  logic                rspAckP0,  // port 0 response ack
  output memGeomPkg::data_t   rspDataP0, // port 0 read data
  output memCmdPkg::tag_t     rspTagP0,  // port 0 read tag
  input  logic                cmdReqP1,  // port 1 command request
  input  memCmdPkg::cmdWord_u cmdWordP1, // port 1 command word
  output logic                cmdAckP1,  // port 1 command ack
  output logic                rspReqP1,  // port 1 response request
  input  logic                rspAckP1,  // port 1 response ack
  output memGeomPkg::data_t   rspDataP1, // port 1 read data
  output memCmdPkg::tag_t     rspTagP1   // port 1 read tag
);

  import memGeomPkg::*;
  import memCmdPkg::*;

  logic  issueValid [`MPRAM_PORTS]; // issue pulse per port
  logic  issueWrite [`MPRAM_PORTS]; // issued command is a write
  addr_t issueAddr  [`MPRAM_PORTS];
  data_t issueData  [`MPRAM_PORTS];
  tag_t  issueTag   [`MPRAM_PORTS];
  logic  slotBusy   [`MPRAM_PORTS]; // back-pressure to the input side
  logic  coreWrEn   [`MPRAM_PORTS]; // write strobe into the core
  logic  rdIssue    [`MPRAM_PORTS]; // read strobe into the output side
  data_t coreRdData [`MPRAM_PORTS];

  // strobes split by command kind
  for (genvar p = 0; p < `MPRAM_PORTS; p++) begin : gStrobe
    assign coreWrEn[p] = issueValid[p] & issueWrite[p];
    assign rdIssue[p]  = issueValid[p] & ~issueWrite[p];
  end

  portRequestSlave slave0_i (
    .clk (clk), .rstN (rstN), .cmdReq (cmdReqP0), .cmdWord (cmdWordP0),
    .slotBusy (slotBusy[0]), .cmdAck (cmdAckP0), .issueValid (issueValid[0]),
    .issueWrite (issueWrite[0]), .issueAddr (issueAddr[0]), .issueData (issueData[0]),
    .issueTag (issueTag[0])
  );

  portRequestSlave slave1_i (
    .clk (clk), .rstN (rstN), .cmdReq (cmdReqP1), .cmdWord (cmdWordP1),
    .slotBusy (slotBusy[1]), .cmdAck (cmdAckP1), .issueValid (issueValid[1]),
    .issueWrite (issueWrite[1]), .issueAddr (issueAddr[1]), .issueData (issueData[1]),
    .issueTag (issueTag[1])
  );

  // reads use the issued address on every issue, writes are masked by coreWrEn
  lvtMultiPortRam core_i (
    .clk    (clk),
    .rstN   (rstN),
    .wrEn   (coreWrEn),
    .wrAddr (issueAddr),
    .wrData (issueData),
    .rdAddr (issueAddr),
    .rdData (coreRdData)
  );

  readReturnMaster master0_i (
    .clk (clk), .rstN (rstN), .rdIssue (rdIssue[0]), .issueTag (issueTag[0]),
    .rdData (coreRdData[0]), .rspAck (rspAckP0), .rspReq (rspReqP0),
    .rspData (rspDataP0), .rspTag (rspTagP0), .slotBusy (slotBusy[0])
  );

  readReturnMaster master1_i (
    .clk (clk), .rstN (rstN), .rdIssue (rdIssue[1]), .issueTag (issueTag[1]),
    .rdData (coreRdData[1]), .rspAck (rspAckP1), .rspReq (rspReqP1),
    .rspData (rspDataP1), .rspTag (rspTagP1), .slotBusy (slotBusy[1])
  );

endmodule

// ==== source/portRequestSlave.sv ====
`timescale 1ns/1ps

module portRequestSlave (
  input  logic                clk,        // clock
  input  logic                rstN,       // sync reset, active low
  input  logic                cmdReq,     // client request, four-phase
  input  memCmdPkg::cmdWord_u cmdWord,    // stable while cmdReq is high
  input  logic                slotBusy,   // response slot still occupied
  output logic                cmdAck,     // four-phase acknowledge
  output logic                issueValid, // one-cycle issue pulse to the core
  output logic                issueWrite, // issued command is a write
  output memGeomPkg::addr_t   issueAddr,  // issued address
  output memGeomPkg::data_t   issueData,  // write data, valid with a write
  output memCmdPkg::tag_t     issueTag    // read tag, valid with a read
);

  typedef enum logic [1:0] {
    idle,     // waiting for cmdReq
    issued,   // issue pulse is out this cycle
    waitDrop  // ack high, waiting for cmdReq to fall
  } slaveState_t;

  slaveState_t state;

  // handshake FSM, exactly one issue per request
  always_ff @(posedge clk) begin
    if (!rstN) begin
      state      <= idle;
      issueValid <= 1'b0;
      cmdAck     <= 1'b0;
    end else begin
      case (state)
        idle: begin
          // writes go straight in, reads wait for a free response slot
          if (cmdReq && (cmdWord.wr.isWrite || !slotBusy)) begin
            issueValid <= 1'b1;
            state      <= issued;
          end
        end
        issued: begin
          issueValid <= 1'b0; // single pulse
          cmdAck     <= 1'b1; // ack the cycle after issue
          state      <= waitDrop;
        end
        default: begin
          if (!cmdReq) begin
            cmdAck <= 1'b0; // phase 4
            state  <= idle;
          end
        end
      endcase
    end
  end

  // command payload, decoded through the view isWrite selects
  always_ff @(posedge clk) begin
    if (state == idle && cmdReq) begin
      issueWrite <= cmdWord.wr.isWrite;
      if (cmdWord.wr.isWrite) begin
        issueAddr <= cmdWord.wr.addr;
        issueData <= cmdWord.wr.data;
      end else begin
        issueAddr <= cmdWord.rd.addr;
        issueTag  <= cmdWord.rd.tag; // only meaningful for reads
      end
    end
  end

endmodule

// ==== source/readReturnMaster.sv ====
`timescale 1ns/1ps

module readReturnMaster (
  input  logic              clk,      // clock
  input  logic              rstN,     // sync reset, active low
  input  logic              rdIssue,  // read issued to the core this cycle
  input  memCmdPkg::tag_t   issueTag, // tag of the issued read
  input  memGeomPkg::data_t rdData,   // core data, valid the cycle after issue
  input  logic              rspAck,   // client acknowledge, four-phase
  output logic              rspReq,   // response request
  output memGeomPkg::data_t rspData,  // read data, stable while rspReq high
  output memCmdPkg::tag_t   rspTag,   // echoed tag
  output logic              slotBusy  // response slot occupied
);

  typedef enum logic [1:0] {
    idle,       // slot free
    waitData,   // read issued, core data arrives this cycle
    present,    // rspReq high, waiting for rspAck
    waitAckLow  // rspReq dropped, waiting for rspAck to fall
  } returnState_t;

  returnState_t state;

  // busy from the issue cycle itself, the FSM only catches up an edge later
  assign slotBusy = rdIssue || (state != idle);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state  <= idle;
      rspReq <= 1'b0;
    end else begin
      case (state)
        idle:       if (rdIssue) state <= waitData;
        waitData: begin
          rspReq <= 1'b1; // same edge the data is captured
          state  <= present;
        end
        present: begin
          if (rspAck) begin
            rspReq <= 1'b0; // drop the cycle after ack is seen
            state  <= waitAckLow;
          end
        end
        default:    if (!rspAck) state <= idle; // handshake done, slot freed
      endcase
    end
  end

  // response payload
  always_ff @(posedge clk) begin
    if (rdIssue) rspTag <= issueTag;         // tag at issue
    if (state == waitData) rspData <= rdData; // data one cycle later
  end

endmodule
